//--- cop_settings.svh
`ifndef COP_SETTINGS_SVH
`define COP_SETTINGS_SVH

// Datapath widths.
`define COP_OPND_W 16
`define COP_RES_W 32

// Queue depths.
`define COP_CMDQ_DEPTH 4  // Command queue.
`define COP_RESQ_DEPTH 8  // Result queue.

// Register offsets within the APB window.
`define COP_ADDR_OP   4'h0
`define COP_ADDR_CMD  4'h4
`define COP_ADDR_RES  4'h8
`define COP_ADDR_STAT 4'hC

`endif

//--- apb_pkg.sv
`include "cop_settings.svh"

package apb_pkg;

  // Request as seen by the slave.
  typedef struct packed {
    logic        sel;
    logic        enable;
    logic        write;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } apb_req_t;

  // Response back to the host.
  typedef struct packed {
    logic        ready;
    logic        slverr;
    logic [31:0] rdata;
  } apb_rsp_t;

  // Register offsets.
  typedef enum logic [3:0] {
    REG_OP   = `COP_ADDR_OP,
    REG_CMD  = `COP_ADDR_CMD,
    REG_RES  = `COP_ADDR_RES,
    REG_STAT = `COP_ADDR_STAT
  } apb_reg_e;

endpackage

//--- cop_pkg.sv
`include "cop_settings.svh"

package cop_pkg;

  // Operations, all on zero-extended operands.
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,  // a + b.
    OP_SUB = 2'd1,  // a - b, wraps modulo 2^32.
    OP_MUL = 2'd2,  // a * b.
    OP_XOR = 2'd3   // a ^ b.
  } cop_op_e;

  // One command in the command queue.
  typedef struct packed {
    cop_op_e                op;
    logic [`COP_OPND_W-1:0] a;
    logic [`COP_OPND_W-1:0] b;
  } cop_cmd_t;

  // One result in the result queue, tagged with its opcode.
  typedef struct packed {
    logic [`COP_RES_W-1:0] value;
    cop_op_e               op;
  } cop_res_t;

  typedef enum logic {
    ENG_IDLE = 1'b0,  // Stage empty.
    ENG_HOLD = 1'b1   // Result waiting for the result queue.
  } eng_state_e;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_flush,

  input  logic [WIDTH-1:0]             i_data,
  input  logic                         i_valid,  // Push request.
  output logic                         o_ready,  // Not full.

  output logic [WIDTH-1:0]             o_data,
  output logic                         o_valid,  // Not empty.
  input  logic                         i_ready,  // Pop request.

  output logic [$clog2(DEPTH+1)-1:0]   o_count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Pointers carry one extra wrap bit above the index.
  logic [PTR_W:0]     wptr_q;
  logic [PTR_W:0]     rptr_q;
  logic [CNT_W-1:0]   count_q;
  logic [WIDTH-1:0]   mem [DEPTH];
  logic               do_push;
  logic               do_pop;
  logic               same_idx;

  // Advance a pointer, toggling the wrap bit at the last entry.
  function automatic logic [PTR_W:0] ptr_inc(input logic [PTR_W:0] ptr);
    logic [PTR_W:0] nxt;
    if (ptr[PTR_W-1:0] == PTR_W'(DEPTH - 1)) begin
      nxt = {~ptr[PTR_W], {PTR_W{1'b0}}};
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign same_idx = (wptr_q[PTR_W-1:0] == rptr_q[PTR_W-1:0]);
  assign o_valid  = !(same_idx && (wptr_q[PTR_W] == rptr_q[PTR_W]));
  assign o_ready  = !(same_idx && (wptr_q[PTR_W] != rptr_q[PTR_W]));

  // A flush wins over both handshakes.
  assign do_push = i_valid && o_ready && !i_flush;
  assign do_pop  = o_valid && i_ready && !i_flush;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (do_push) wptr_q <= ptr_inc(wptr_q);
      if (do_pop)  rptr_q <= ptr_inc(rptr_q);
    end
  end

  // Occupancy counter, kept apart from the pointers.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      count_q <= '0;
    end else if (do_push && !do_pop) begin
      count_q <= count_q + 1'b1;
    end else if (do_pop && !do_push) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign o_count = count_q;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wptr_q[PTR_W-1:0]] <= i_data;
    end
  end

  assign o_data = mem[rptr_q[PTR_W-1:0]];  // Head entry.

endmodule

//--- apb_regs.sv
`timescale 1ns/1ps

module apb_regs (
  input  logic              i_clk,
  input  logic              i_rst_n,

  input  apb_pkg::apb_req_t i_apb,
  output apb_pkg::apb_rsp_t o_apb,

  output cop_pkg::cop_cmd_t o_cmd,
  output logic              o_cmd_valid,
  input  logic              i_cmd_ready,

  input  cop_pkg::cop_res_t i_res,
  input  logic              i_res_valid,
  output logic              o_res_ready,

  input  logic [3:0]        i_cmd_count,
  input  logic [3:0]        i_res_count,

  output logic              o_flush
);

  import apb_pkg::*;
  import cop_pkg::*;

  logic        access;
  logic        wr_op;
  logic [31:0] stat_word;
  cop_op_e     op_q;

  // Access phase of a transfer. No wait states.
  assign access = i_apb.sel && i_apb.enable;

  // Status word for STAT reads.
  assign stat_word = {14'b0, !i_res_valid, !i_cmd_ready,
                      4'b0, i_res_count, 4'b0, i_cmd_count};

  // Command built from the write data and the current opcode.
  assign o_cmd.op = op_q;
  assign o_cmd.a  = i_apb.wdata[31:16];
  assign o_cmd.b  = i_apb.wdata[15:0];

  always_comb begin
    o_apb.ready  = access;
    o_apb.slverr = 1'b0;
    o_apb.rdata  = '0;
    o_cmd_valid  = 1'b0;
    o_res_ready  = 1'b0;
    o_flush      = 1'b0;
    wr_op        = 1'b0;
    if (access) begin
      case (i_apb.addr)
        REG_OP: begin
          if (i_apb.write) wr_op = 1'b1;
          else o_apb.rdata = {30'b0, op_q};
        end
        REG_CMD: begin
          // Push offered on every write. A full queue drops it.
          o_cmd_valid  = i_apb.write;
          o_apb.slverr = !i_apb.write || !i_cmd_ready;
        end
        REG_RES: begin
          if (!i_apb.write && i_res_valid) begin
            o_res_ready = 1'b1;          // Pop the head.
            o_apb.rdata = i_res.value;
          end else begin
            o_apb.slverr = 1'b1;         // Empty queue or write.
          end
        end
        REG_STAT: begin
          if (i_apb.write) o_flush = i_apb.wdata[0];
          else o_apb.rdata = stat_word;
        end
        default: o_apb.slverr = 1'b1;  // Unmapped offset.
      endcase
    end
  end

  // Opcode register.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      op_q <= OP_ADD;
    end else if (wr_op) begin
      op_q <= cop_op_e'(i_apb.wdata[1:0]);
    end
  end

endmodule

//--- op_engine.sv
`timescale 1ns/1ps
`include "cop_settings.svh"

module op_engine (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_flush,

  input  cop_pkg::cop_cmd_t i_cmd,
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,

  output cop_pkg::cop_res_t o_res,
  output logic              o_res_valid,
  input  logic              i_res_ready
);

  import cop_pkg::*;

  eng_state_e            state_q;
  cop_res_t              res_q;
  logic                  take;
  logic [`COP_RES_W-1:0] a_ext;
  logic [`COP_RES_W-1:0] b_ext;
  logic [`COP_RES_W-1:0] alu_out;

  // Stage is free when empty or when its result leaves this cycle.
  assign o_cmd_ready = (state_q == ENG_IDLE) || i_res_ready;
  assign take        = i_cmd_valid && o_cmd_ready && !i_flush;

  assign a_ext = `COP_RES_W'(i_cmd.a);  // Zero extension.
  assign b_ext = `COP_RES_W'(i_cmd.b);

  always_comb begin
    case (i_cmd.op)
      OP_ADD:  alu_out = a_ext + b_ext;
      OP_SUB:  alu_out = a_ext - b_ext;  // Wraps.
      OP_MUL:  alu_out = a_ext * b_ext;
      OP_XOR:  alu_out = a_ext ^ b_ext;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      state_q <= ENG_IDLE;  // A flush drops any held result.
    end else begin
      case (state_q)
        ENG_IDLE: if (take) state_q <= ENG_HOLD;
        ENG_HOLD: if (i_res_ready && !take) state_q <= ENG_IDLE;
        default:  state_q <= ENG_IDLE;
      endcase
    end
  end

  // Result register.
  always_ff @(posedge i_clk) begin
    if (take) begin
      res_q.value <= alu_out;
      res_q.op    <= i_cmd.op;
    end
  end

  assign o_res       = res_q;
  assign o_res_valid = (state_q == ENG_HOLD);

endmodule

//--- cop_top.sv
`timescale 1ns/1ps
`include "cop_settings.svh"

module cop_top (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  apb_pkg::apb_req_t i_apb,
  output apb_pkg::apb_rsp_t o_apb
);

  import cop_pkg::*;

  localparam int CMD_W      = $bits(cop_cmd_t);
  localparam int RES_W      = $bits(cop_res_t);
  localparam int CMDQ_CNT_W = $clog2(`COP_CMDQ_DEPTH + 1);
  localparam int RESQ_CNT_W = $clog2(`COP_RESQ_DEPTH + 1);

  cop_cmd_t              cmd_in, cmd_head;
  cop_res_t              res_in, res_head;
  logic                  cmd_in_valid, cmd_in_ready, cmd_head_valid, cmd_head_ready;
  logic                  res_in_valid, res_in_ready, res_head_valid, res_head_ready;
  logic [CMDQ_CNT_W-1:0] cmd_count;
  logic [RESQ_CNT_W-1:0] res_count;
  logic                  flush;

  apb_regs apb_regs_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_apb(i_apb), .o_apb(o_apb),
    .o_cmd(cmd_in), .o_cmd_valid(cmd_in_valid), .i_cmd_ready(cmd_in_ready),
    .i_res(res_head), .i_res_valid(res_head_valid), .o_res_ready(res_head_ready),
    .i_cmd_count(4'(cmd_count)), .i_res_count(4'(res_count)), .o_flush(flush)
  );

  sync_fifo #(.WIDTH(CMD_W), .DEPTH(`COP_CMDQ_DEPTH)) cmd_q (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(flush),
    .i_data(cmd_in), .i_valid(cmd_in_valid), .o_ready(cmd_in_ready),
    .o_data(cmd_head), .o_valid(cmd_head_valid), .i_ready(cmd_head_ready),
    .o_count(cmd_count)
  );

  op_engine op_engine_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(flush),
    .i_cmd(cmd_head), .i_cmd_valid(cmd_head_valid), .o_cmd_ready(cmd_head_ready),
    .o_res(res_in), .o_res_valid(res_in_valid), .i_res_ready(res_in_ready)
  );

  sync_fifo #(.WIDTH(RES_W), .DEPTH(`COP_RESQ_DEPTH)) res_q (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(flush),
    .i_data(res_in), .i_valid(res_in_valid), .o_ready(res_in_ready),
    .o_data(res_head), .o_valid(res_head_valid), .i_ready(res_head_ready),
    .o_count(res_count)
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;  // Released between edges.
  end

endmodule

//--- cop_sva.sv
`timescale 1ns/1ps

module cop_sva #(
  parameter int DEPTH = 1
) (
  input logic       i_clk,
  input logic       i_rst_n,
  input logic       i_sel,
  input logic       i_enable,
  input logic       i_ready,
  input logic       i_push,
  input logic       i_pop,
  input logic       i_full,
  input logic       i_empty,
  input logic [7:0] i_count
);

  // An access phase always follows a setup phase.
  a_ready_in_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ready |-> (i_sel && i_enable && $past(i_sel && !i_enable)))
    else $error("pready high outside an access phase");

  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_push |-> !i_full)
    else $error("FIFO push while full");

  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> !i_empty)
    else $error("FIFO pop while empty");

  a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_count <= 8'(DEPTH))
    else $error("FIFO count above its depth");

endmodule

// Register block, APB side only.
bind apb_regs cop_sva apb_sva_i (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_sel(i_apb.sel), .i_enable(i_apb.enable), .i_ready(o_apb.ready),
  .i_push(1'b0), .i_pop(1'b0), .i_full(1'b0), .i_empty(1'b0), .i_count(8'd0)
);

// Both queues. Full and empty come from the counter, the handshakes from the pointers.
bind sync_fifo cop_sva #(.DEPTH(DEPTH)) fifo_sva_i (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_sel(1'b0), .i_enable(1'b0), .i_ready(1'b0),
  .i_push(do_push), .i_pop(do_pop),
  .i_full(count_q == CNT_W'(DEPTH)), .i_empty(count_q == '0),
  .i_count(8'(count_q))
);

//--- cop_tb.sv
`timescale 1ns/1ps
`include "cop_settings.svh"

module cop_tb;

  import apb_pkg::*;
  import cop_pkg::*;

  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 + 100;  // 200 per test plus margin.

  logic                  clk;
  logic                  rst_n;
  apb_req_t              apb_req;
  apb_rsp_t              apb_rsp;
  logic [31:0]           rng_state;
  string                 test_name;
  logic [`COP_RES_W-1:0] exp_q[$];  // Results in issue order.

  tb_clk_gen #(.PERIOD(10), .RST_CYCLES(3)) tb_clk_gen_i (.o_clk(clk), .o_rst_n(rst_n));

  cop_top cop_top_i (.i_clk(clk), .i_rst_n(rst_n), .i_apb(apb_req), .o_apb(apb_rsp));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference arithmetic on zero-extended operands.
  function automatic logic [`COP_RES_W-1:0] model_op(input cop_op_e op,
      input logic [`COP_OPND_W-1:0] a, input logic [`COP_OPND_W-1:0] b);
    logic [`COP_RES_W-1:0] ax;
    logic [`COP_RES_W-1:0] bx;
    ax = {{(`COP_RES_W - `COP_OPND_W){1'b0}}, a};
    bx = {{(`COP_RES_W - `COP_OPND_W){1'b0}}, b};
    case (op)
      OP_ADD:  return ax + bx;
      OP_SUB:  return ax + ~bx + 32'd1;  // Two's complement, wraps.
      OP_MUL:  return ax * bx;
      default: return ax ^ bx;
    endcase
  endfunction

  function automatic logic [31:0] stat_of(input int cmd_cnt, input int res_cnt);
    logic [31:0] s;
    s       = '0;
    s[3:0]  = 4'(cmd_cnt);
    s[11:8] = 4'(res_cnt);
    s[16]   = (cmd_cnt == `COP_CMDQ_DEPTH);  // Command queue full.
    s[17]   = (res_cnt == 0);                // Result queue empty.
    return s;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check_res(input logic [`COP_RES_W-1:0] exp, input logic [`COP_RES_W-1:0] act);
    if (act !== exp) begin
      $display("** Error %s: result expected %h, actual %h", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_stat(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: status expected %h, actual %h", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: pslverr expected %b, actual %b", test_name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_op(input cop_op_e exp, input cop_op_e act);
    if (act !== exp) begin
      $display("** Error %s: opcode expected %0d, actual %0d", test_name, exp, act);
      abort_run();
    end
  endtask

  // One APB transfer. Setup phase, then access phase.
  task automatic do_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
    @(negedge clk);
    apb_req.sel    = 1'b1;
    apb_req.enable = 1'b0;
    apb_req.write  = wr;
    apb_req.addr   = addr;
    apb_req.wdata  = wdata;
    @(negedge clk);
    apb_req.enable = 1'b1;
    #2;  // Inside the access phase, before the rising edge.
    if (apb_rsp.ready !== 1'b1) begin
      $display("APB transfer at offset %h did not complete in its access phase", addr);
      abort_run();
    end
    rdata = apb_rsp.rdata;
    err   = apb_rsp.slverr;
    @(negedge clk);
    apb_req.sel    = 1'b0;
    apb_req.enable = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    do_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    do_transfer(1'b0, addr, '0, data, err);
  endtask

  // Sets OP and writes CMD with random operands.
  task automatic issue_cmd(input cop_op_e op, input logic exp_err);
    logic [31:0] r;
    logic        err;
    rng_state = xorshift(rng_state);
    r = rng_state;
    apb_write(`COP_ADDR_OP, {30'b0, op}, err);
    check_err(1'b0, err);
    apb_write(`COP_ADDR_CMD, r, err);
    check_err(exp_err, err);
    if (!exp_err) exp_q.push_back(model_op(op, r[31:16], r[15:0]));
  endtask

  task automatic wait_results(input int n);
    logic [31:0] s;
    logic        err;
    s = '0;
    while (int'(s[11:8]) < n) apb_read(`COP_ADDR_STAT, s, err);
  endtask

  task automatic pop_expect();
    logic [31:0] data;
    logic        err;
    apb_read(`COP_ADDR_RES, data, err);
    check_err(1'b0, err);
    check_res(exp_q.pop_front(), data);
  endtask

  task automatic expect_stat(input int cmd_cnt, input int res_cnt);
    logic [31:0] data;
    logic        err;
    apb_read(`COP_ADDR_STAT, data, err);
    check_err(1'b0, err);
    check_stat(stat_of(cmd_cnt, res_cnt), data);
  endtask

  task automatic expect_op(input cop_op_e exp);
    logic [31:0] data;
    logic        err;
    apb_read(`COP_ADDR_OP, data, err);
    check_err(1'b0, err);
    check_op(exp, cop_op_e'(data[1:0]));
  endtask

  task automatic test_reset_status();
    logic [31:0] data;
    logic        err;
    test_name = "test_reset_status";
    expect_stat(0, 0);
    expect_op(OP_ADD);
    apb_read(`COP_ADDR_RES, data, err);
    check_err(1'b1, err);
    check_res('0, data);
  endtask

  task automatic test_each_op();
    test_name = "test_each_op";
    for (int k = 0; k < 4; k++) begin
      issue_cmd(cop_op_e'(2'(k)), 1'b0);
      expect_op(cop_op_e'(2'(k)));
      wait_results(1);
      pop_expect();
    end
  endtask

  task automatic test_order_many();
    test_name = "test_order_many";
    for (int batch = 0; batch < 3; batch++) begin
      for (int i = 0; i < `COP_CMDQ_DEPTH; i++) begin
        rng_state = xorshift(rng_state);
        issue_cmd(cop_op_e'(rng_state[1:0]), 1'b0);
      end
      wait_results(`COP_CMDQ_DEPTH);
      for (int left = `COP_CMDQ_DEPTH; left > 0; left--) begin
        expect_stat(0, left);  // One fewer per read.
        pop_expect();
      end
    end
    expect_stat(0, 0);
  endtask

  task automatic test_backpressure();
    logic [31:0] data;
    logic        err;
    test_name = "test_backpressure";
    for (int i = 0; i < `COP_RESQ_DEPTH + 1 + `COP_CMDQ_DEPTH; i++) begin
      issue_cmd(cop_op_e'(2'(i)), 1'b0);
    end
    issue_cmd(OP_ADD, 1'b1);  // Dropped.
    expect_stat(`COP_CMDQ_DEPTH, `COP_RESQ_DEPTH);
    while (exp_q.size() > 0) begin
      wait_results(1);
      pop_expect();
    end
    expect_stat(0, 0);
    apb_read(`COP_ADDR_RES, data, err);
    check_err(1'b1, err);
  endtask

  task automatic test_flush();
    logic [31:0] data;
    logic        err;
    test_name = "test_flush";
    // Fills the result queue, one held in the engine, two waiting.
    for (int i = 0; i < `COP_RESQ_DEPTH + 3; i++) issue_cmd(OP_SUB, 1'b0);
    expect_stat(2, `COP_RESQ_DEPTH);
    apb_write(`COP_ADDR_STAT, 32'h1, err);
    check_err(1'b0, err);
    exp_q.delete();
    expect_stat(0, 0);
    apb_read(`COP_ADDR_RES, data, err);
    check_err(1'b1, err);
    issue_cmd(OP_MUL, 1'b0);
    wait_results(1);
    pop_expect();
  endtask

  task automatic test_bad_address();
    logic [31:0] data;
    logic        err;
    test_name = "test_bad_address";
    issue_cmd(OP_XOR, 1'b0);
    wait_results(1);
    apb_read(4'h2, data, err);
    check_err(1'b1, err);
    apb_write(4'h6, 32'hFFFF_FFFF, err);
    check_err(1'b1, err);
    expect_stat(0, 1);
    pop_expect();
  endtask

  initial begin
    apb_req   = '0;
    rng_state = 32'd46550;
    test_name = "none";
    @(posedge rst_n);
    test_reset_status();
    test_each_op();
    test_order_many();
    test_backpressure();
    test_flush();
    test_bad_address();
    $display("Test passed");
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles with tests still running", TIMEOUT_CYCLES);
    abort_run();
  end

endmodule

//--- vlog.f
+incdir+.
apb_pkg.sv
cop_pkg.sv
sync_fifo.sv
apb_regs.sv
op_engine.sv
cop_top.sv
tb_clk_gen.sv
cop_sva.sv
cop_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cop_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) cop_settings.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@! grep -q "Test failed" $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
